/* design/data_requester.sv */
////////////////////////////////////////
// in-order load/store queue in front of memory
// head goes out as a bus command; each departure returns
// one credit upstream, loads also return their data
////////////////////////////////////////
`default_nettype none

module data_requester (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   op_valid,
    input  mem_access_pkg::data_op_t               op,
    input  logic                                   accept,
    input  logic                                   reply_valid,
    input  logic [mem_access_pkg::block_width-1:0] reply_data,
    output mem_access_pkg::mem_req_t               request,
    output mem_access_pkg::load_result_t           load_result,
    output logic                                   data_credit
);
    import mem_access_pkg::*;

    localparam int ptr_width = $clog2(data_queue_depth);
    localparam int cnt_width = $clog2(data_queue_depth + 1);

    data_op_t               queue [data_queue_depth];
    logic [ptr_width-1:0]   head;
    logic [ptr_width-1:0]   tail;
    logic [cnt_width-1:0]   count;
    logic                   load_wait;
    data_op_t               head_op;
    logic                   pop;
    logic                   result_valid;
    logic [op_id_width-1:0] result_id;
    logic [block_width-1:0] result_data;

    assign head_op = queue[head];

    // head is blocked while its load waits for a reply
    always_comb begin
        request = '{cmd: bus_none, addr: head_op.addr, data: head_op.data};
        if (count != '0 && !load_wait) begin
            request.cmd = (head_op.op == op_load) ? bus_load : bus_store;
        end
    end

    // store leaves at acceptance, load at its reply
    assign pop = (accept && head_op.op == op_store) || reply_valid;

    assign load_result = '{valid: result_valid, id: result_id, data: result_data};

    ////////////////////////////////////////
    // queue storage
    ////////////////////////////////////////
    // pushes are credit limited so the queue never overflows
    always_ff @(posedge clock) begin
        if (op_valid) begin
            queue[tail] <= op;
        end
    end

    ////////////////////////////////////////
    // pointers, count, credits
    ////////////////////////////////////////
    // depth is a power of two, pointers wrap on their own
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            load_wait    <= 1'b0;
            data_credit  <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            if (op_valid) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({op_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // accepted load parks the head until its data returns
            if (accept && head_op.op == op_load) begin
                load_wait <= 1'b1;
            end else if (reply_valid) begin
                load_wait <= 1'b0;
            end
            data_credit  <= pop;
            result_valid <= reply_valid;
        end
    end

    // load result payload
    always_ff @(posedge clock) begin
        if (reply_valid) begin
            result_id   <= head_op.id;
            result_data <= reply_data;
        end
    end

endmodule

`default_nettype wire

/* design/fetch_requester.sv */
////////////////////////////////////////
// sequential instruction block fetch
// one load in flight, gated by consumer buffer credits
////////////////////////////////////////
`default_nettype none

module fetch_requester (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  fetch_credit,
    input  logic                                  accept,
    input  logic                                  reply_valid,
    input  logic [mem_access_pkg::block_width-1:0] reply_data,
    output mem_access_pkg::mem_req_t              request,
    output mem_access_pkg::fetch_block_t          fetch_block
);
    import mem_access_pkg::*;

    logic [addr_width-1:0]                fetch_addr;
    logic [$clog2(fetch_credits+1)-1:0]   credits;
    logic                                 pending;
    logic                                 block_valid;
    logic [addr_width-1:0]                block_addr;
    logic [block_width-1:0]               block_data;

    // ask only with a free slot downstream and nothing outstanding
    assign request.cmd  = (credits != '0 && !pending) ? bus_load : bus_none;
    assign request.addr = fetch_addr;
    assign request.data = '0;

    assign fetch_block = '{valid: block_valid, addr: block_addr, data: block_data};

    ////////////////////////////////////////
    // control state
    ////////////////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            fetch_addr  <= '0;
            credits     <= ($clog2(fetch_credits+1))'(fetch_credits);
            pending     <= 1'b0;
            block_valid <= 1'b0;
        end else begin
            // slot spent at acceptance, returned by the consumer
            case ({fetch_credit, accept})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
            if (accept) begin
                pending <= 1'b1;
            end else if (reply_valid) begin
                pending    <= 1'b0;
                fetch_addr <= fetch_addr + addr_width'(fetch_stride);
            end
            block_valid <= reply_valid;
        end
    end

    // block payload, captured with the address it was fetched from
    always_ff @(posedge clock) begin
        if (reply_valid) begin
            block_addr <= fetch_addr;
            block_data <= reply_data;
        end
    end

endmodule

`default_nettype wire

/* design/mem_access_pkg.sv */
////////////////////////////////////////
// shared types and constants for the memory access path
// imported by every design module and by the testbench
////////////////////////////////////////
`default_nettype none

package mem_access_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////
    localparam int addr_width       = 32;
    localparam int block_width      = 64;
    // tag and response share this width, zero means none
    localparam int tag_width        = 4;
    localparam int op_id_width      = 4;
    // consumer slots owned by fetch at reset
    localparam int fetch_credits    = 2;
    // queue slots, also the upstream's starting credits
    localparam int data_queue_depth = 4;
    // one 8-byte block per fetch
    localparam int fetch_stride     = 8;

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        bus_none  = 2'd0,
        bus_load  = 2'd1,
        bus_store = 2'd2
    } bus_cmd_e;

    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } data_op_e;

    ////////////////////////////////////////
    // bundles
    ////////////////////////////////////////
    // one command toward memory
    typedef struct packed {
        bus_cmd_e               cmd;
        logic [addr_width-1:0]  addr;
        logic [block_width-1:0] data;
    } mem_req_t;

    // reply from memory, tag of zero means no reply this cycle
    typedef struct packed {
        logic [tag_width-1:0]   tag;
        logic [block_width-1:0] data;
    } mem_reply_t;

    // operation pushed by the upstream into the data queue
    typedef struct packed {
        data_op_e               op;
        logic [op_id_width-1:0] id;
        logic [addr_width-1:0]  addr;
        logic [block_width-1:0] data;
    } data_op_t;

    typedef struct packed {
        logic                   valid;
        logic [addr_width-1:0]  addr;
        logic [block_width-1:0] data;
    } fetch_block_t;

    typedef struct packed {
        logic                   valid;
        logic [op_id_width-1:0] id;
        logic [block_width-1:0] data;
    } load_result_t;

endpackage

`default_nettype wire

/* design/mem_access_top.sv */
////////////////////////////////////////
// memory access top level
// fetch and data requesters side by side on one memory port
////////////////////////////////////////
`default_nettype none

module mem_access_top (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 fetch_credit,
    input  logic                                 op_valid,
    input  mem_access_pkg::data_op_t             op,
    output logic                                 data_credit,
    output mem_access_pkg::fetch_block_t         fetch_block,
    output mem_access_pkg::load_result_t         load_result,
    output mem_access_pkg::mem_req_t             mem_req,
    input  logic [mem_access_pkg::tag_width-1:0] mem_response,
    input  mem_access_pkg::mem_reply_t           mem_reply
);
    import mem_access_pkg::*;

    ////////////////////////////////////////
    // requester to arbiter wires
    ////////////////////////////////////////
    mem_req_t               fetch_request;
    mem_req_t               data_request;
    logic                   fetch_accept;
    logic                   data_accept;
    logic                   fetch_reply_valid;
    logic                   data_reply_valid;
    // reply data fans out to both, valids pick the owner
    logic [block_width-1:0] reply_data;

    fetch_requester i_fetch (
        .clock       (clock),
        .reset       (reset),
        .fetch_credit(fetch_credit),
        .accept      (fetch_accept),
        .reply_valid (fetch_reply_valid),
        .reply_data  (reply_data),
        .request     (fetch_request),
        .fetch_block (fetch_block)
    );

    data_requester i_data (
        .clock      (clock),
        .reset      (reset),
        .op_valid   (op_valid),
        .op         (op),
        .accept     (data_accept),
        .reply_valid(data_reply_valid),
        .reply_data (reply_data),
        .request    (data_request),
        .load_result(load_result),
        .data_credit(data_credit)
    );

    mem_arbiter i_arbiter (
        .clock            (clock),
        .reset            (reset),
        .fetch_request    (fetch_request),
        .data_request     (data_request),
        .mem_response     (mem_response),
        .mem_reply        (mem_reply),
        .mem_req          (mem_req),
        .fetch_accept     (fetch_accept),
        .data_accept      (data_accept),
        .fetch_reply_valid(fetch_reply_valid),
        .data_reply_valid (data_reply_valid),
        .reply_data       (reply_data)
    );

endmodule

`default_nettype wire

/* design/mem_arbiter.sv */
////////////////////////////////////////
// shared memory port for fetch and data traffic
// data side wins, tags are owned per requester and
// replies are steered back by tag match
////////////////////////////////////////
`default_nettype none

module mem_arbiter (
    input  logic                                   clock,
    input  logic                                   reset,
    input  mem_access_pkg::mem_req_t               fetch_request,
    input  mem_access_pkg::mem_req_t               data_request,
    input  logic [mem_access_pkg::tag_width-1:0]   mem_response,
    input  mem_access_pkg::mem_reply_t             mem_reply,
    output mem_access_pkg::mem_req_t               mem_req,
    output logic                                   fetch_accept,
    output logic                                   data_accept,
    output logic                                   fetch_reply_valid,
    output logic                                   data_reply_valid,
    output logic [mem_access_pkg::block_width-1:0] reply_data
);
    import mem_access_pkg::*;

    logic                 sel_data;
    logic                 accepted;
    logic [tag_width-1:0] fetch_tag;
    logic                 fetch_tag_valid;
    logic [tag_width-1:0] load_tag;
    logic                 load_tag_valid;
    logic                 reply_present;

    ////////////////////////////////////////
    // request side
    ////////////////////////////////////////
    // data first, fetch only when the data side is idle
    assign sel_data = (data_request.cmd != bus_none);
    assign mem_req  = sel_data ? data_request : fetch_request;

    // nonzero response is a tag, zero means retry next cycle
    assign accepted     = (mem_response != '0) && (mem_req.cmd != bus_none);
    assign data_accept  = accepted && sel_data;
    assign fetch_accept = accepted && !sel_data;

    ////////////////////////////////////////
    // reply side
    ////////////////////////////////////////
    assign reply_present     = (mem_reply.tag != '0);
    assign fetch_reply_valid = reply_present && fetch_tag_valid && mem_reply.tag == fetch_tag;
    assign data_reply_valid  = reply_present && load_tag_valid && mem_reply.tag == load_tag;
    assign reply_data        = mem_reply.data;

    // tag ownership, one fetch and one load in flight at most
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            fetch_tag       <= '0;
            fetch_tag_valid <= 1'b0;
            load_tag        <= '0;
            load_tag_valid  <= 1'b0;
        end else begin
            // free on reply
            if (fetch_reply_valid) begin
                fetch_tag_valid <= 1'b0;
            end
            if (data_reply_valid) begin
                load_tag_valid <= 1'b0;
            end
            // claim on acceptance
            if (fetch_accept) begin
                fetch_tag       <= mem_response;
                fetch_tag_valid <= 1'b1;
            end
            // stores never reply, no owner kept
            if (data_accept && data_request.cmd == bus_load) begin
                load_tag       <= mem_response;
                load_tag_valid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* flist.f */
design/mem_access_pkg.sv
design/fetch_requester.sv
design/data_requester.sv
design/mem_arbiter.sv
design/mem_access_top.sv
sim/clock_gen.sv
sim/mem_arbiter_checker.sv
sim/mem_access_tb.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module mem_access_tb \
    -Mdir obj_dir -o sim_mem_access
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_mem_access > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

/* sim/clock_gen.sv */
////////////////////////////////////////
// testbench clock and reset source
// 10 unit period, reset held for 8 rising edges
////////////////////////////////////////
`default_nettype none

module clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // release just after an edge, like the other inputs
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* sim/mem_access_tb.sv */
////////////////////////////////////////
// testbench for the memory access top level
// memory model with random refusals and latency,
// credit-limited stimulus, in-order result checking
////////////////////////////////////////
`default_nettype none

module mem_access_tb;
    import mem_access_pkg::*;

    localparam int          num_ops         = 48;
    localparam int          max_latency     = 6;
    localparam int          watchdog_cycles = 400 + (num_ops + 16) * (max_latency + 2) * 4;
    localparam logic [31:0] seed            = 32'hb51e537c;
    // data region, far above anything fetch reaches
    localparam logic [31:0] data_base       = 32'h1000_0000;

    // one in-flight reply of the memory model
    typedef struct packed {
        logic       valid;
        logic [2:0] delay;
        mem_reply_t reply;
    } pending_reply_t;

    logic                 clock;
    logic                 reset;
    logic                 fetch_credit;
    logic                 op_valid;
    data_op_t             op;
    logic                 data_credit;
    fetch_block_t         fetch_block;
    load_result_t         load_result;
    mem_req_t             mem_req;
    logic [tag_width-1:0] mem_response;
    mem_reply_t           mem_reply;

    pending_reply_t       replies [4];
    logic [tag_width-1:0] next_tag;
    logic [31:0]          mem_rng;
    logic [31:0]          stim_rng;
    logic [63:0]          data_mem [logic [31:0]];
    // shadow memory in push order, for expected loads
    logic [63:0]          ref_mem [logic [31:0]];
    load_result_t         expected_loads [$];
    // data commands memory should see, in push order
    mem_req_t             expected_reqs [$];
    int                   fetches_accepted;
    int                   blocks_seen;
    int                   credits_given;
    int                   return_limit;
    int                   pushed;
    int                   loads_pushed;
    int                   loads_seen;
    int                   credits_back;
    int                   fetch_mark;

    clock_gen i_clock_gen (
        .clock(clock),
        .reset(reset)
    );

    mem_access_top i_dut (
        .clock       (clock),
        .reset       (reset),
        .fetch_credit(fetch_credit),
        .op_valid    (op_valid),
        .op          (op),
        .data_credit (data_credit),
        .fetch_block (fetch_block),
        .load_result (load_result),
        .mem_req     (mem_req),
        .mem_response(mem_response),
        .mem_reply   (mem_reply)
    );

    ////////////////////////////////////////
    // helpers and reference
    ////////////////////////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // initial content of every address
    function automatic logic [63:0] block_pattern(input logic [31:0] addr);
        return {addr ^ 32'hc3a5_961e, ~addr + 32'h0101_0101};
    endfunction

    // value a load pushed now must see
    function automatic logic [63:0] reference_value(input logic [31:0] addr);
        return ref_mem.exists(addr) ? ref_mem[addr] : block_pattern(addr);
    endfunction

    function automatic fetch_block_t expected_fetch(input int n);
        logic [31:0] a;
        a = addr_width'(n * fetch_stride);
        return '{valid: 1'b1, addr: a, data: block_pattern(a)};
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        stop_with_failure($sformatf("Fail at time %0t: %s is %h, expected %h",
                                    $time, name, got, exp));
    endtask

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////
    task automatic check_fetch(input fetch_block_t got, input fetch_block_t exp);
        if (got.addr !== exp.addr) begin
            report_mismatch("fetch_block.addr", 64'(got.addr), 64'(exp.addr));
        end
        if (got.data !== exp.data) begin
            report_mismatch("fetch_block.data", got.data, exp.data);
        end
    endtask

    task automatic check_load(input load_result_t got, input load_result_t exp);
        if (got.id !== exp.id) begin
            report_mismatch("load_result.id", 64'(got.id), 64'(exp.id));
        end
        if (got.data !== exp.data) begin
            report_mismatch("load_result.data", got.data, exp.data);
        end
    endtask

    // command seen by memory at acceptance
    task automatic check_request(input mem_req_t got, input mem_req_t exp);
        if (got.cmd !== exp.cmd) begin
            report_mismatch("mem_req.cmd", 64'(got.cmd), 64'(exp.cmd));
        end
        if (got.addr !== exp.addr) begin
            report_mismatch("mem_req.addr", 64'(got.addr), 64'(exp.addr));
        end
        // load data is don't care
        if (exp.cmd == bus_store && got.data !== exp.data) begin
            report_mismatch("mem_req.data", got.data, exp.data);
        end
    endtask

    // one pulse per departed operation, never ahead of the pushes
    task automatic check_credit(input logic pulse);
        if (pulse) begin
            credits_back++;
            if (credits_back > pushed) begin
                stop_with_failure("data_credit pulsed with no operation in the queue");
            end
        end
    endtask

    ////////////////////////////////////////
    // memory model
    ////////////////////////////////////////
    task automatic accept_command();
        int       slot;
        mem_req_t exp;
        slot = -1;
        // data region commands follow push order, fetch walks the blocks
        if (mem_req.addr >= data_base) begin
            if (expected_reqs.size() == 0) begin
                stop_with_failure("data command accepted with no operation queued");
            end else begin
                check_request(mem_req, expected_reqs.pop_front());
            end
        end else begin
            exp.cmd  = bus_load;
            exp.addr = addr_width'(fetches_accepted * fetch_stride);
            exp.data = '0;
            check_request(mem_req, exp);
            fetches_accepted++;
        end
        if (mem_req.cmd == bus_store) begin
            data_mem[mem_req.addr] = mem_req.data;
        end else begin
            for (int s = 0; s < 4; s++) begin
                if (!replies[s].valid && slot < 0) begin
                    slot = s;
                end
            end
            if (slot < 0) begin
                stop_with_failure("memory model has no free reply slot");
            end else begin
                mem_rng = xorshift(mem_rng);
                replies[slot].valid = 1'b1;
                replies[slot].delay = 3'(32'd1 + mem_rng % 32'(max_latency));
                replies[slot].reply.tag = mem_response;
                replies[slot].reply.data = data_mem.exists(mem_req.addr) ?
                                           data_mem[mem_req.addr] : block_pattern(mem_req.addr);
            end
        end
        // rotate through the nonzero tags
        next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
    endtask

    initial begin : memory_model
        mem_response = '0;
        mem_reply = '0;
        next_tag = 4'd1;
        mem_rng = seed;
        for (int s = 0; s < 4; s++) begin
            replies[s] = '0;
        end
        forever begin
            @(posedge clock);
            #1;
            // age replies, send at most one that is due
            mem_reply = '0;
            for (int s = 0; s < 4; s++) begin
                if (replies[s].valid && replies[s].delay != 3'd0) begin
                    replies[s].delay = replies[s].delay - 3'd1;
                end
            end
            for (int s = 0; s < 4; s++) begin
                if (replies[s].valid && replies[s].delay == 3'd0 && mem_reply.tag == '0) begin
                    mem_reply = replies[s].reply;
                    replies[s].valid = 1'b0;
                end
            end
            // a quarter of the cycles refuse
            mem_rng = xorshift(mem_rng);
            mem_response = (mem_rng[1:0] == 2'b00) ? '0 : next_tag;
            @(negedge clock);
            if (!reset && mem_req.cmd != bus_none && mem_response != '0) begin
                accept_command();
            end
        end
    end

    ////////////////////////////////////////
    // consumer of fetch blocks
    ////////////////////////////////////////
    // gives a slot back per received block, up to return_limit
    initial begin : consumer
        fetch_credit = 1'b0;
        forever begin
            @(posedge clock);
            #1;
            fetch_credit = 1'b0;
            if (!reset && credits_given < blocks_seen && credits_given < return_limit) begin
                fetch_credit = 1'b1;
                credits_given++;
            end
        end
    end

    ////////////////////////////////////////
    // compare process
    ////////////////////////////////////////
    always @(negedge clock) begin
        if (!reset) begin
            if (fetch_block.valid) begin
                check_fetch(fetch_block, expected_fetch(blocks_seen));
                blocks_seen++;
                if (blocks_seen > fetch_credits + credits_given) begin
                    stop_with_failure("fetch delivered more blocks than consumer slots");
                end
            end
            if (load_result.valid) begin
                if (expected_loads.size() == 0) begin
                    stop_with_failure("load_result valid with no load outstanding");
                end else begin
                    check_load(load_result, expected_loads.pop_front());
                end
                // a load's slot comes back with its result
                if (!data_credit) begin
                    stop_with_failure("load_result valid without its data_credit pulse");
                end
                loads_seen++;
            end
            check_credit(data_credit);
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    task automatic push_op(input logic [31:0] r);
        data_op_t o;
        mem_req_t req;
        o.op = r[8] ? op_store : op_load;
        o.id = op_id_width'(pushed);
        // four block addresses so loads and stores overlap
        o.addr = data_base + addr_width'({r[12:11], 3'b000});
        o.data = {r, r ^ 32'h9e37_79b9};
        if (o.op == op_load) begin
            expected_loads.push_back('{valid: 1'b1, id: o.id, data: reference_value(o.addr)});
            loads_pushed++;
        end else begin
            ref_mem[o.addr] = o.data;
        end
        req.cmd  = (o.op == op_store) ? bus_store : bus_load;
        req.addr = o.addr;
        req.data = o.data;
        expected_reqs.push_back(req);
        op = o;
        op_valid = 1'b1;
        pushed++;
    endtask

    initial begin : stimulus
        op_valid = 1'b0;
        op = '0;
        return_limit = 0;
        stim_rng = ~seed;
        while (reset) @(negedge clock);
        // no slots returned yet, fetch must stop at its credits
        while (blocks_seen < fetch_credits) @(negedge clock);
        repeat (30) @(negedge clock);
        // one more block per returned slot
        for (int k = 1; k <= 3; k++) begin
            return_limit = k;
            while (blocks_seen < fetch_credits + k) @(negedge clock);
            repeat (20) @(negedge clock);
        end
        return_limit = 1 << 30;
        fetch_mark = blocks_seen;
        // data traffic under upstream credits, fetch keeps running
        while (pushed < num_ops) begin
            @(posedge clock);
            #1;
            op_valid = 1'b0;
            stim_rng = xorshift(stim_rng);
            if (pushed - credits_back < data_queue_depth && stim_rng[2:0] != 3'd0) begin
                push_op(stim_rng);
            end
        end
        @(posedge clock);
        #1;
        op_valid = 1'b0;
        while (loads_seen != loads_pushed || credits_back != num_ops ||
               blocks_seen < fetch_mark + 8) @(negedge clock);
        repeat (10) @(negedge clock);
        if (expected_reqs.size() == 0 && expected_loads.size() == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            stop_with_failure("an operation left the queue without reaching memory");
        end
    end

    // bound from the test length and worst reply latency
    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clock);
        stop_with_failure("watchdog expired before all operations completed");
    end

endmodule

`default_nettype wire

/* sim/mem_arbiter_checker.sv */
////////////////////////////////////////
// protocol assertions on the memory arbiter
// attached to every mem_arbiter instance by bind
////////////////////////////////////////
`default_nettype none

module mem_arbiter_checker (
    input logic                                 clock,
    input logic                                 reset,
    input logic [mem_access_pkg::tag_width-1:0] mem_response,
    input logic                                 fetch_accept,
    input logic                                 data_accept,
    input logic                                 fetch_reply_valid,
    input logic                                 data_reply_valid
);

    // one command per cycle, so one owner per acceptance
    accept_one_hot: assert property (@(posedge clock) disable iff (reset)
        !(fetch_accept && data_accept))
        else $error("fetch and data accepted in the same cycle");

    // zero response is a refusal
    accept_needs_tag: assert property (@(posedge clock) disable iff (reset)
        (fetch_accept || data_accept) |-> (mem_response != '0))
        else $error("accept pulse without a memory tag");

    // tags are unique among outstanding owners
    reply_one_owner: assert property (@(posedge clock) disable iff (reset)
        !(fetch_reply_valid && data_reply_valid))
        else $error("reply steered to both requesters");

endmodule

bind mem_arbiter mem_arbiter_checker i_checker (
    .clock            (clock),
    .reset            (reset),
    .mem_response     (mem_response),
    .fetch_accept     (fetch_accept),
    .data_accept      (data_accept),
    .fetch_reply_valid(fetch_reply_valid),
    .data_reply_valid (data_reply_valid)
);

`default_nettype wire
